//--- hdl/l2w_consts.svh
`ifndef L2W_CONSTS_SVH
`define L2W_CONSTS_SVH

// ----------------------------------------------------------------------
// line geometry
// ----------------------------------------------------------------------

`define L2W_OFFSET_WIDTH  2                            // log2 of the words in a line.
`define L2W_LINE_WORDS    (1 << `L2W_OFFSET_WIDTH)
`define L2W_LINE_BITS     (32 * `L2W_LINE_WORDS)

// ----------------------------------------------------------------------
// burst size encodings
// ----------------------------------------------------------------------

`define L2W_SIZE_WORD     3'd2                         // four bytes per beat.
`define L2W_SIZE_UNCACHED 3'd1

`endif

//--- hdl/l2w_pkg.sv
`include "l2w_consts.svh"

package l2w_pkg;

    // ------------------------------------------------------------------
    // write controller state
    // ------------------------------------------------------------------

    typedef enum logic [4:0] {
        idle   = 5'd0,
        dma_aw = 5'd1,
        dma_w  = 5'd2,
        dma_r  = 5'd3,
        wrt_w  = 5'd4                                  // uncached write waits for the buffer.
    } ctrl_state_t;

    // ------------------------------------------------------------------
    // request and channel payloads
    // ------------------------------------------------------------------

    typedef struct packed {
        logic [31:0]               addr;
        logic [`L2W_LINE_BITS-1:0] data;               // word 0 sits in the low bits.
    } line_req_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;                              // beats minus one.
        logic [2:0]  size;
        logic [3:0]  strb;
    } mem_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } mem_w_t;

endpackage

//--- hdl/l2_write_ctrl.sv
`timescale 1ns/1ps

module l2_write_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_w,
    input  logic                 uncached,
    input  logic                 buf_busy,
    input  logic                 awready,
    input  logic                 wready,
    input  logic                 bvalid,
    output l2w_pkg::ctrl_state_t crt
);

    l2w_pkg::ctrl_state_t nxt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            crt <= l2w_pkg::idle;
        end else begin
            crt <= nxt;
        end
    end

    // ------------------------------------------------------------------
    // next state
    // ------------------------------------------------------------------

    always_comb begin
        nxt = crt;
        case (crt)
            l2w_pkg::idle: begin
                if (req_w && uncached) begin
                    nxt = buf_busy ? l2w_pkg::wrt_w : l2w_pkg::dma_aw; // never pass a line.
                end
            end
            l2w_pkg::wrt_w: begin
                if (!buf_busy) begin
                    nxt = l2w_pkg::dma_aw;
                end
            end
            l2w_pkg::dma_aw: begin
                if (awready) begin
                    nxt = l2w_pkg::dma_w;
                end
            end
            l2w_pkg::dma_w: begin
                if (wready) begin
                    nxt = l2w_pkg::dma_r;
                end
            end
            l2w_pkg::dma_r: begin
                if (bvalid) begin
                    nxt = l2w_pkg::idle;                   // the cache sees addr_ok here.
                end
            end
            default: begin
                nxt = l2w_pkg::idle;
            end
        endcase
    end

endmodule

//--- hdl/write_arbiter.sv
`timescale 1ns/1ps

`include "l2w_consts.svh"

module write_arbiter (
    input  l2w_pkg::ctrl_state_t      crt,
    // cache side
    input  logic                      req_w,
    input  logic                      uncached,
    input  logic [31:0]               req_addr,
    input  logic [`L2W_LINE_BITS-1:0] req_data,
    input  logic [3:0]                req_wstrb,
    output logic                      addr_ok,
    // write buffer side
    output l2w_pkg::line_req_t        buf_req,
    output logic                      buf_req_w,
    input  logic                      buf_addr_ok,
    input  l2w_pkg::mem_aw_t          buf_aw,
    input  logic                      buf_awvalid,
    input  l2w_pkg::mem_w_t           buf_w,
    input  logic                      buf_wvalid,
    input  logic                      buf_bready,
    output logic                      buf_awready,
    output logic                      buf_wready,
    output logic                      buf_bvalid,
    // memory side
    output l2w_pkg::mem_aw_t          mem_aw,
    output logic                      awvalid,
    output l2w_pkg::mem_w_t           mem_w,
    output logic                      wvalid,
    output logic                      bready,
    input  logic                      awready,
    input  logic                      wready,
    input  logic                      bvalid
);

    always_comb begin
        addr_ok     = 1'b0;
        buf_req     = '0;
        buf_req_w   = 1'b0;
        buf_awready = 1'b0;
        buf_wready  = 1'b0;
        buf_bvalid  = 1'b0;
        mem_aw      = '0;
        awvalid     = 1'b0;
        mem_w       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;

        case (crt)
            l2w_pkg::dma_aw: begin
                mem_aw.addr = req_addr;
                mem_aw.len  = 8'd0;
                mem_aw.size = `L2W_SIZE_UNCACHED;
                mem_aw.strb = req_wstrb;
                mem_w.data  = req_data[31:0];
                awvalid     = 1'b1;
            end
            l2w_pkg::dma_w: begin
                mem_aw.addr = req_addr;
                mem_aw.len  = 8'd0;
                mem_aw.size = `L2W_SIZE_UNCACHED;
                mem_aw.strb = req_wstrb;
                mem_w.data  = req_data[31:0];
                mem_w.last  = 1'b1;                    // single beat is also the last.
                awvalid     = 1'b1;
                wvalid      = 1'b1;
            end
            l2w_pkg::dma_r: begin
                bready  = 1'b1;
                addr_ok = bvalid;                      // response closes the uncached request.
            end
            default: begin
                // idle and wrt_w route the cache to the buffer and the buffer to memory.
                addr_ok     = buf_addr_ok;
                buf_req     = '{addr: req_addr, data: req_data};
                buf_req_w   = req_w && !uncached;
                mem_aw      = buf_aw;
                awvalid     = buf_awvalid;
                mem_w       = buf_w;
                wvalid      = buf_wvalid;
                bready      = buf_bready;
                buf_awready = awready;
                buf_wready  = wready;
                buf_bvalid  = bvalid;
            end
        endcase
    end

endmodule

//--- hdl/write_buffer.sv
`timescale 1ns/1ps

`include "l2w_consts.svh"

module write_buffer (
    input  logic               clk,
    input  logic               rst_n,
    input  l2w_pkg::line_req_t buf_req,
    input  logic               buf_req_w,
    output logic               buf_addr_ok,
    output logic               buf_busy,
    output l2w_pkg::mem_aw_t   mem_aw,
    output logic               awvalid,
    output l2w_pkg::mem_w_t    mem_w,
    output logic               wvalid,
    output logic               bready,
    input  logic               awready,
    input  logic               wready,
    input  logic               bvalid
);

    localparam logic [`L2W_OFFSET_WIDTH-1:0] last_beat =
        `L2W_OFFSET_WIDTH'(`L2W_LINE_WORDS - 1);

    typedef enum logic [1:0] {
        ph_empty,
        ph_addr,
        ph_data,
        ph_resp
    } phase_t;

    phase_t                        phase;
    l2w_pkg::line_req_t            line;
    logic [`L2W_OFFSET_WIDTH-1:0]  beat;
    logic                          take;

    assign take = (phase == ph_empty) && buf_req_w;

    // ------------------------------------------------------------------
    // phase sequencing
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= ph_empty;
            beat  <= '0;
        end else begin
            case (phase)
                ph_empty: begin
                    if (buf_req_w) begin
                        phase <= ph_addr;
                    end
                end
                ph_addr: begin
                    if (awready) begin
                        phase <= ph_data;
                    end
                end
                ph_data: begin
                    if (wready) begin
                        beat <= beat + `L2W_OFFSET_WIDTH'(1); // wraps back to word 0.
                        if (beat == last_beat) begin
                            phase <= ph_resp;
                        end
                    end
                end
                ph_resp: begin
                    if (bvalid) begin
                        phase <= ph_empty;
                    end
                end
                default: begin
                    phase <= ph_empty;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            line <= buf_req;
        end
    end

    // ------------------------------------------------------------------
    // cache handshake and memory channels
    // ------------------------------------------------------------------

    assign buf_addr_ok = take;                        // acknowledged in the request cycle.
    assign buf_busy    = (phase != ph_empty);

    always_comb begin
        mem_aw.addr = line.addr;
        mem_aw.len  = 8'(`L2W_LINE_WORDS - 1);
        mem_aw.size = `L2W_SIZE_WORD;
        mem_aw.strb = 4'hF;
        awvalid     = (phase == ph_addr);

        mem_w.data  = line.data[beat*32 +: 32];
        mem_w.last  = (phase == ph_data) && (beat == last_beat);
        wvalid      = (phase == ph_data);

        bready      = (phase == ph_resp);
    end

endmodule

//--- hdl/l2_write_path.sv
`timescale 1ns/1ps

`include "l2w_consts.svh"

module l2_write_path (
    input  logic                      clk,
    input  logic                      rst_n,
    // cache side
    input  logic                      req_w,
    input  logic                      uncached,
    input  logic [31:0]               req_addr,
    input  logic [`L2W_LINE_BITS-1:0] req_data,
    input  logic [3:0]                req_wstrb,
    output logic                      addr_ok,
    // memory side
    output l2w_pkg::mem_aw_t          mem_aw,
    output logic                      awvalid,
    input  logic                      awready,
    output l2w_pkg::mem_w_t           mem_w,
    output logic                      wvalid,
    input  logic                      wready,
    input  logic                      bvalid,
    output logic                      bready
);

    l2w_pkg::ctrl_state_t crt;
    l2w_pkg::line_req_t   buf_req;
    logic                 buf_req_w;
    logic                 buf_addr_ok;
    logic                 buf_busy;
    l2w_pkg::mem_aw_t     buf_aw;
    logic                 buf_awvalid;
    l2w_pkg::mem_w_t      buf_w;
    logic                 buf_wvalid;
    logic                 buf_bready;
    logic                 buf_awready;
    logic                 buf_wready;
    logic                 buf_bvalid;

    l2_write_ctrl u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_w    (req_w),
        .uncached (uncached),
        .buf_busy (buf_busy),
        .awready  (awready),
        .wready   (wready),
        .bvalid   (bvalid),
        .crt      (crt)
    );

    write_arbiter u_arb (
        .crt         (crt),
        .req_w       (req_w),
        .uncached    (uncached),
        .req_addr    (req_addr),
        .req_data    (req_data),
        .req_wstrb   (req_wstrb),
        .addr_ok     (addr_ok),
        .buf_req     (buf_req),
        .buf_req_w   (buf_req_w),
        .buf_addr_ok (buf_addr_ok),
        .buf_aw      (buf_aw),
        .buf_awvalid (buf_awvalid),
        .buf_w       (buf_w),
        .buf_wvalid  (buf_wvalid),
        .buf_bready  (buf_bready),
        .buf_awready (buf_awready),
        .buf_wready  (buf_wready),
        .buf_bvalid  (buf_bvalid),
        .mem_aw      (mem_aw),
        .awvalid     (awvalid),
        .mem_w       (mem_w),
        .wvalid      (wvalid),
        .bready      (bready),
        .awready     (awready),
        .wready      (wready),
        .bvalid      (bvalid)
    );

    write_buffer u_buf (
        .clk         (clk),
        .rst_n       (rst_n),
        .buf_req     (buf_req),
        .buf_req_w   (buf_req_w),
        .buf_addr_ok (buf_addr_ok),
        .buf_busy    (buf_busy),
        .mem_aw      (buf_aw),
        .awvalid     (buf_awvalid),
        .mem_w       (buf_w),
        .wvalid      (buf_wvalid),
        .bready      (buf_bready),
        .awready     (buf_awready),
        .wready      (buf_wready),
        .bvalid      (buf_bvalid)
    );

endmodule

//--- tb/l2_write_path_chk.sv
`timescale 1ns/1ps

module l2_write_path_chk (
    input logic             clk,
    input logic             rst_n,
    input logic             addr_ok,
    input l2w_pkg::mem_aw_t mem_aw,
    input logic             awvalid,
    input logic             awready,
    input l2w_pkg::mem_w_t  mem_w,
    input logic             wvalid,
    input logic             wready,
    input logic             bvalid,
    input logic             bready
);

    int unsigned fails = 0;

    // ------------------------------------------------------------------
    // channel stability
    // ------------------------------------------------------------------

    // an uncached write restates its address next to the data beat,
    // so this rule covers the address phase on its own.
    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready && !wvalid |=> awvalid && $stable(mem_aw))
        else begin
            $error("awvalid dropped or mem_aw changed before awready");
            fails++;
        end

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(mem_w))
        else begin
            $error("wvalid dropped or mem_w changed before wready");
            fails++;
        end

    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bready && !bvalid |=> bready)
        else begin
            $error("bready dropped before bvalid");
            fails++;
        end

    last_valid: assert property (@(posedge clk) disable iff (!rst_n)
        mem_w.last |-> wvalid)
        else begin
            $error("mem_w.last raised without wvalid");
            fails++;
        end

    // ------------------------------------------------------------------
    // reset behavior
    // ------------------------------------------------------------------

    ok_in_reset: assert property (@(posedge clk) !rst_n |-> !addr_ok)
        else begin
            $error("addr_ok raised while reset is active");
            fails++;
        end

    aw_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !awvalid)
        else begin
            $error("awvalid high right after reset");
            fails++;
        end

endmodule

bind l2_write_path l2_write_path_chk u_chk (.*);

//--- tb/l2_write_path_tb.sv
`timescale 1ns/1ps

`include "l2w_consts.svh"

module l2_write_path_tb;

    localparam int n_directed      = 4;
    localparam int n_total         = n_directed + 40;
    localparam int stall_depth     = 256;
    localparam int watchdog_cycles = n_total * 40 + 20;
    localparam int ch_aw           = 0;
    localparam int ch_w            = 1;
    localparam int ch_b            = 2;

    typedef struct packed {
        logic                      unc;
        logic [31:0]               addr;
        logic [`L2W_LINE_BITS-1:0] data;
        logic [3:0]                strb;
        logic [1:0]                gap;                    // idle cycles before the request.
    } cache_req_t;

    typedef struct packed {
        logic [31:0]                      addr;
        logic [7:0]                       len;
        logic [2:0]                       size;
        logic [3:0]                       strb;
        logic [`L2W_LINE_WORDS-1:0][31:0] words;
        logic [`L2W_LINE_WORDS-1:0]       last;
    } wr_rec_t;

    logic                      clk;
    logic                      rst_n;
    logic                      req_w;
    logic                      uncached;
    logic [31:0]               req_addr;
    logic [`L2W_LINE_BITS-1:0] req_data;
    logic [3:0]                req_wstrb;
    logic                      addr_ok;
    l2w_pkg::mem_aw_t          mem_aw;
    logic                      awvalid;
    logic                      awready;
    l2w_pkg::mem_w_t           mem_w;
    logic                      wvalid;
    logic                      wready;
    logic                      bvalid;
    logic                      bready;

    cache_req_t  reqs [n_total];
    int unsigned stalls [stall_depth];
    int unsigned stall_idx;
    wr_rec_t     exp_q [$];
    wr_rec_t     got_q [$];
    int unsigned issued;
    int unsigned checked;

    l2_write_path UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // error reporting
    // ------------------------------------------------------------------

    task automatic abort_run();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, want);
        abort_run();
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        abort_run();
    endtask

    // ------------------------------------------------------------------
    // stimulus and reference
    // ------------------------------------------------------------------

    task automatic make_stimulus();
        int i;
        int w;
        for (i = 0; i < n_total; i++) begin
            reqs[i].unc  = (i < n_directed) ? i[0] : 1'($urandom_range(1));
            reqs[i].addr = $urandom;
            if (reqs[i].unc) begin
                reqs[i].addr[1:0] = 2'b00;
            end else begin
                reqs[i].addr[3:0] = 4'h0;                  // lines are 16 byte aligned.
            end
            for (w = 0; w < `L2W_LINE_WORDS; w++) begin
                reqs[i].data[w*32 +: 32] = $urandom;
            end
            reqs[i].strb = 4'($urandom_range(15, 1));
            reqs[i].gap  = (i < n_directed) ? 2'd0 : 2'($urandom_range(2));
        end
        for (i = 0; i < stall_depth; i++) begin
            stalls[i] = $urandom_range(3);
        end
    endtask

    function automatic int unsigned next_stall();
        int unsigned s;
        s         = stalls[stall_idx];
        stall_idx = (stall_idx + 1) % stall_depth;
        return s;
    endfunction

    function automatic wr_rec_t expect_record(input cache_req_t r);
        wr_rec_t e;
        int      w;
        e      = '0;
        e.addr = r.addr;
        if (r.unc) begin
            e.len      = 8'd0;
            e.size     = 3'd1;
            e.strb     = r.strb;
            e.words[0] = r.data[31:0];                     // only word 0 goes out.
            e.last[0]  = 1'b1;
        end else begin
            e.len  = 8'd3;
            e.size = 3'd2;
            e.strb = 4'hF;
            for (w = 0; w < `L2W_LINE_WORDS; w++) begin
                e.words[w] = r.data[w*32 +: 32];
            end
            e.last[`L2W_LINE_WORDS-1] = 1'b1;
        end
        return e;
    endfunction

    task automatic issue_request(input cache_req_t r, input logic at_once);
        int unsigned waited;
        repeat (r.gap) @(negedge clk);
        exp_q.push_back(expect_record(r));
        issued++;
        @(negedge clk);
        req_w     = 1'b1;
        uncached  = r.unc;
        req_addr  = r.addr;
        req_data  = r.data;
        req_wstrb = r.strb;
        waited    = 0;
        forever begin
            @(posedge clk);
            if (addr_ok) break;
            waited++;
        end
        if (r.unc) begin
            assert (bvalid && bready)
                else report_problem("addr_ok for an uncached write came before its response");
        end
        if (at_once) begin
            assert (waited == 0)
                else report_problem($sformatf("addr_ok for a writeback came %0d cycles late",
                                              waited));
        end
        @(negedge clk);
        req_w    = 1'b0;
        uncached = 1'b0;
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            assert (!addr_ok) else report_mismatch("addr_ok", 32'(addr_ok), 32'h0);
            assert (!awvalid) else report_mismatch("awvalid", 32'(awvalid), 32'h0);
            assert (!wvalid) else report_mismatch("wvalid", 32'(wvalid), 32'h0);
            assert (!bready) else report_mismatch("bready", 32'(bready), 32'h0);
        end
    endtask

    // ------------------------------------------------------------------
    // memory slave, comparison and watchdog
    // ------------------------------------------------------------------

    task automatic complete_handshake(input int chan);
        int unsigned stall;
        stall = next_stall();
        forever begin
            @(negedge clk);
            awready = (chan == ch_aw) && (stall == 0);
            wready  = (chan == ch_w) && (stall == 0);
            bvalid  = (chan == ch_b) && (stall == 0);
            if (stall != 0) stall = stall - 1;
            @(posedge clk);
            if ((chan == ch_aw && awvalid && awready) || (chan == ch_w && wvalid && wready) ||
                (chan == ch_b && bvalid && bready)) break;
        end
    endtask

    task automatic serve_memory();
        wr_rec_t rec;
        int      b;
        forever begin
            rec = '0;
            complete_handshake(ch_aw);
            rec.addr = mem_aw.addr;
            rec.len  = mem_aw.len;
            rec.size = mem_aw.size;
            rec.strb = mem_aw.strb;
            assert (rec.len < `L2W_LINE_WORDS)
                else report_problem($sformatf("burst of %0d beats is longer than a line",
                                              rec.len + 1));
            for (b = 0; b <= rec.len; b++) begin
                complete_handshake(ch_w);
                rec.words[b] = mem_w.data;
                rec.last[b]  = mem_w.last;
            end
            complete_handshake(ch_b);
            got_q.push_back(rec);
        end
    endtask

    task automatic compare_log();
        wr_rec_t got;
        wr_rec_t want;
        int      w;
        forever begin
            @(negedge clk);
            while (got_q.size() != 0) begin
                got = got_q.pop_front();
                assert (exp_q.size() != 0)
                    else report_problem("memory saw a write that the cache never issued");
                want = exp_q.pop_front();
                assert (got.addr == want.addr)
                    else report_mismatch("mem_aw.addr", got.addr, want.addr);
                assert (got.len == want.len)
                    else report_mismatch("mem_aw.len", 32'(got.len), 32'(want.len));
                assert (got.size == want.size)
                    else report_mismatch("mem_aw.size", 32'(got.size), 32'(want.size));
                assert (got.strb == want.strb)
                    else report_mismatch("mem_aw.strb", 32'(got.strb), 32'(want.strb));
                for (w = 0; w < `L2W_LINE_WORDS; w++) begin
                    assert (got.words[w] == want.words[w])
                        else report_mismatch($sformatf("mem_w.data[%0d]", w),
                                             got.words[w], want.words[w]);
                    assert (got.last[w] == want.last[w])
                        else report_mismatch($sformatf("mem_w.last[%0d]", w),
                                             32'(got.last[w]), 32'(want.last[w]));
                end
                checked++;
            end
        end
    endtask

    task automatic watch_protocol();
        forever begin
            @(negedge clk);
            assert (UUT.u_chk.fails == 0)
                else report_problem("a protocol assertion on the memory port failed");
        end
    endtask

    task automatic watch_time();
        repeat (watchdog_cycles) @(posedge clk);
        report_problem($sformatf("timeout after %0d cycles with %0d of %0d writes checked",
                                 watchdog_cycles, checked, n_total));
    endtask

    initial begin : main
        int i;
        rst_n     = 1'b0;
        req_w     = 1'b0;
        uncached  = 1'b0;
        req_addr  = '0;
        req_data  = '0;
        req_wstrb = '0;
        awready   = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        issued    = 0;
        checked   = 0;
        stall_idx = 0;
        void'($urandom(90));
        make_stimulus();
        repeat (4) @(posedge clk);
        fork
            serve_memory();
            compare_log();
            watch_protocol();
            watch_time();
        join_none
        @(negedge clk);
        rst_n = 1'b1;
        check_quiet(5);
        // requests 1 and 3 are uncached writes right behind a writeback.
        for (i = 0; i < n_total; i++) begin
            issue_request(reqs[i], (i == 0) || (i == 2));
        end
        while (checked != issued) @(negedge clk);
        repeat (5) @(negedge clk);
        if (got_q.size() == 0 && exp_q.size() == 0 && UUT.u_chk.fails == 0) begin
            $display("No errors");
            $finish;
        end else begin
            report_problem("writes were left unmatched or a protocol assertion failed");
        end
    end

endmodule

//--- files.f
+incdir+hdl
hdl/l2w_pkg.sv
hdl/l2_write_ctrl.sv
hdl/write_arbiter.sv
hdl/write_buffer.sv
hdl/l2_write_path.sv
tb/l2_write_path_chk.sv
tb/l2_write_path_tb.sv
